// File: cpu_types_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the EX/MEM/WB pipeline
// word and register index, opcode, ALU op,
// memory op and pipeline bubble values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_types_pkg;

	// basic widths
	localparam int WORD_W = 32;
	localparam int REG_W = 5;
	localparam int SHAMT_W = 5;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] regbits_t;

	// MIPS primary opcodes that reach the execute stage
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0C,
		OP_ORI   = 6'h0D,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B,
		OP_HALT  = 6'h3F
	} opcode_t;

	// ALU operations, already decoded upstream
	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SUB = 4'h1,
		ALU_AND = 4'h2,
		ALU_OR  = 4'h3,
		ALU_XOR = 4'h4,
		ALU_NOR = 4'h5,
		// signed compare
		ALU_SLT = 4'h6,
		ALU_SLL = 4'h7,
		ALU_SRL = 4'h8
	} aluop_t;

	// what the memory stage does with an instruction
	typedef enum logic [1:0] {
		MEM_NONE  = 2'b00,
		MEM_READ  = 2'b01,
		MEM_WRITE = 2'b10
	} mem_op_t;

	// bubble contents loaded on reset and flush
	localparam word_t WORD_RESET = '0;
	localparam regbits_t REG_RESET = '0;
	localparam mem_op_t MEM_OP_RESET = MEM_NONE;

	// writes to this register are discarded
	localparam regbits_t REG_ZERO = '0;

endpackage

// File: ex_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage
// ALU and control derivation per opcode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ex_stage import cpu_types_pkg::*; (
	input  opcode_t  opcode,
	input  aluop_t   alu_op,
	input  word_t    rdat1,
	input  word_t    rdat2,
	input  word_t    imm16_ext,
	input  regbits_t rt,
	input  regbits_t rd,
	output word_t    result,
	output word_t    store_data,
	output regbits_t dest_reg,
	output logic     reg_wen,
	output mem_op_t  mem_op,
	output logic     halt
);

	word_t  operand_b;
	aluop_t op_sel;

	// immediate is operand B for everything but R-type
	assign operand_b = (opcode == OP_RTYPE) ? rdat2 : imm16_ext;

	// address calculation always adds
	assign op_sel = (opcode == OP_LW || opcode == OP_SW) ? ALU_ADD : alu_op;

	always_comb begin
		case (op_sel)
			ALU_ADD: result = rdat1 + operand_b;
			ALU_SUB: result = rdat1 - operand_b;
			ALU_AND: result = rdat1 & operand_b;
			ALU_OR:  result = rdat1 | operand_b;
			ALU_XOR: result = rdat1 ^ operand_b;
			ALU_NOR: result = ~(rdat1 | operand_b);
			ALU_SLT: result = ($signed(rdat1) < $signed(operand_b)) ? word_t'(1) : '0;
			ALU_SLL: result = rdat1 << operand_b[SHAMT_W-1:0];
			ALU_SRL: result = rdat1 >> operand_b[SHAMT_W-1:0];
			default: result = '0;
		endcase
	end

	assign store_data = rdat2;
	assign dest_reg = (opcode == OP_RTYPE) ? rd : rt;

	// write flag, memory op and halt from the opcode
	always_comb begin
		reg_wen = 1'b0;
		mem_op = MEM_NONE;
		halt = 1'b0;
		case (opcode)
			OP_RTYPE, OP_ADDI, OP_ANDI, OP_ORI: reg_wen = 1'b1;
			OP_LW: begin
				reg_wen = 1'b1;
				mem_op = MEM_READ;
			end
			OP_SW:   mem_op = MEM_WRITE;
			OP_HALT: halt = 1'b1;
			default: reg_wen = 1'b0;
		endcase
	end

endmodule

// File: ex_mem_reg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EX/MEM pipeline register
// bubble on flush, hold while stalled
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ex_mem_reg import cpu_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     stall,
	input  logic     flush,
	input  word_t    result,
	input  word_t    store_data,
	input  regbits_t dest_reg,
	input  logic     reg_wen,
	input  mem_op_t  mem_op,
	input  logic     halt,
	output word_t    result_ex_mem,
	output word_t    store_data_ex_mem,
	output regbits_t dest_reg_ex_mem,
	output logic     reg_wen_ex_mem,
	output mem_op_t  mem_op_ex_mem,
	output logic     halt_ex_mem
);

	word_t    result_reg, result_nxt;
	word_t    store_data_reg, store_data_nxt;
	regbits_t dest_reg_reg, dest_reg_nxt;
	logic     reg_wen_reg, reg_wen_nxt;
	mem_op_t  mem_op_reg, mem_op_nxt;
	logic     halt_reg, halt_nxt;

	assign result_ex_mem = result_reg;
	assign store_data_ex_mem = store_data_reg;
	assign dest_reg_ex_mem = dest_reg_reg;
	assign reg_wen_ex_mem = reg_wen_reg;
	assign mem_op_ex_mem = mem_op_reg;
	assign halt_ex_mem = halt_reg;

	always_comb begin : NXT_LOGIC
		// hold by default
		result_nxt = result_reg;
		store_data_nxt = store_data_reg;
		dest_reg_nxt = dest_reg_reg;
		reg_wen_nxt = reg_wen_reg;
		mem_op_nxt = mem_op_reg;
		halt_nxt = halt_reg;

		// flush wins over stall
		if (flush) begin
			result_nxt = WORD_RESET;
			store_data_nxt = WORD_RESET;
			dest_reg_nxt = REG_RESET;
			reg_wen_nxt = 1'b0;
			mem_op_nxt = MEM_OP_RESET;
			halt_nxt = 1'b0;
		end else if (!stall) begin
			result_nxt = result;
			store_data_nxt = store_data;
			dest_reg_nxt = dest_reg;
			reg_wen_nxt = reg_wen;
			mem_op_nxt = mem_op;
			halt_nxt = halt;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin : REG_LOGIC
		if (!nRST) begin
			result_reg <= WORD_RESET;
			store_data_reg <= WORD_RESET;
			dest_reg_reg <= REG_RESET;
			reg_wen_reg <= 1'b0;
			mem_op_reg <= MEM_OP_RESET;
			halt_reg <= 1'b0;
		end else begin
			result_reg <= result_nxt;
			store_data_reg <= store_data_nxt;
			dest_reg_reg <= dest_reg_nxt;
			reg_wen_reg <= reg_wen_nxt;
			mem_op_reg <= mem_op_nxt;
			halt_reg <= halt_nxt;
		end
	end

endmodule

// File: mem_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage
// credit-based data memory port,
// load wait tracking and stall
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_stage import cpu_types_pkg::*; #(
	parameter int DMEM_CREDITS = 2
) (
	input  logic    CLK,
	input  logic    nRST,
	input  mem_op_t mem_op_ex_mem,
	input  word_t   result_ex_mem,
	input  word_t   store_data_ex_mem,
	input  logic    dmem_credit,
	input  logic    dmem_rvalid,
	input  word_t   dmem_rdata,
	output logic    dmem_req,
	output logic    dmem_we,
	output word_t   dmem_addr,
	output word_t   dmem_wdata,
	output logic    stall,
	output word_t   load_data
);

	// wide enough to hold the full credit count
	localparam int CNT_W = $clog2(DMEM_CREDITS + 1);

	logic [CNT_W-1:0] credits_reg, credits_nxt;
	logic             issued_reg, issued_nxt;
	logic             mem_active;
	logic             op_done;

	assign mem_active = (mem_op_ex_mem != MEM_NONE);

	// one request per instruction, only with a credit in hand
	assign dmem_req = mem_active && !issued_reg && (credits_reg != '0);
	assign dmem_we = (mem_op_ex_mem == MEM_WRITE);
	assign dmem_addr = result_ex_mem;
	assign dmem_wdata = store_data_ex_mem;
	assign load_data = dmem_rdata;

	// store is done once issued, load once its data is back
	always_comb begin
		case (mem_op_ex_mem)
			MEM_WRITE: op_done = dmem_req;
			MEM_READ:  op_done = issued_reg && dmem_rvalid;
			default:   op_done = 1'b1;
		endcase
	end

	assign stall = mem_active && !op_done;

	always_comb begin
		credits_nxt = credits_reg;
		case ({dmem_credit, dmem_req})
			2'b10:   credits_nxt = credits_reg + CNT_W'(1);
			2'b01:   credits_nxt = credits_reg - CNT_W'(1);
			default: credits_nxt = credits_reg;
		endcase
	end

	// issued flag belongs to whatever sits in EX/MEM
	always_comb begin
		issued_nxt = issued_reg;
		if (!mem_active || op_done)
			issued_nxt = 1'b0;
		else if (dmem_req)
			issued_nxt = 1'b1;
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			credits_reg <= CNT_W'(DMEM_CREDITS);
			issued_reg <= 1'b0;
		end else begin
			credits_reg <= credits_nxt;
			issued_reg <= issued_nxt;
		end
	end

endmodule

// File: mem_wb_reg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM/WB pipeline register
// writeback data select, r0 write drop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_wb_reg import cpu_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     stall,
	input  word_t    result_ex_mem,
	input  word_t    load_data,
	input  regbits_t dest_reg_ex_mem,
	input  logic     reg_wen_ex_mem,
	input  mem_op_t  mem_op_ex_mem,
	input  logic     halt_ex_mem,
	output logic     wb_wen,
	output regbits_t wb_addr,
	output word_t    wb_data,
	output logic     halt_out
);

	logic     wb_wen_nxt;
	regbits_t wb_addr_nxt;
	word_t    wb_data_nxt;
	logic     halt_nxt;

	always_comb begin
		// bubble while the memory stage waits
		wb_wen_nxt = 1'b0;
		wb_addr_nxt = REG_RESET;
		wb_data_nxt = WORD_RESET;
		halt_nxt = 1'b0;
		if (!stall) begin
			wb_wen_nxt = reg_wen_ex_mem && (dest_reg_ex_mem != REG_ZERO);
			wb_addr_nxt = dest_reg_ex_mem;
			wb_data_nxt = (mem_op_ex_mem == MEM_READ) ? load_data : result_ex_mem;
			halt_nxt = halt_ex_mem;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_wen <= 1'b0;
			wb_addr <= REG_RESET;
			wb_data <= WORD_RESET;
			halt_out <= 1'b0;
		end else begin
			wb_wen <= wb_wen_nxt;
			wb_addr <= wb_addr_nxt;
			wb_data <= wb_data_nxt;
			halt_out <= halt_nxt;
		end
	end

endmodule

// File: ex_mem_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute, memory and writeback pipeline
// top level with the data memory port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ex_mem_top import cpu_types_pkg::*; #(
	parameter int DMEM_CREDITS = 2
) (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     flush,
	input  opcode_t  opcode,
	input  aluop_t   alu_op,
	input  word_t    rdat1,
	input  word_t    rdat2,
	input  word_t    imm16_ext,
	input  regbits_t rt,
	input  regbits_t rd,
	input  logic     dmem_credit,
	input  logic     dmem_rvalid,
	input  word_t    dmem_rdata,
	output logic     stall,
	output logic     wb_wen,
	output regbits_t wb_addr,
	output word_t    wb_data,
	output logic     halt_out,
	output logic     dmem_req,
	output logic     dmem_we,
	output word_t    dmem_addr,
	output word_t    dmem_wdata
);

	// execute stage outputs
	word_t    result, store_data;
	regbits_t dest_reg;
	logic     reg_wen, halt;
	mem_op_t  mem_op;

	// EX/MEM register outputs
	word_t    result_ex_mem, store_data_ex_mem;
	regbits_t dest_reg_ex_mem;
	logic     reg_wen_ex_mem, halt_ex_mem;
	mem_op_t  mem_op_ex_mem;

	word_t    load_data;

	ex_stage ex_stage_inst (
		.opcode     (opcode),
		.alu_op     (alu_op),
		.rdat1      (rdat1),
		.rdat2      (rdat2),
		.imm16_ext  (imm16_ext),
		.rt         (rt),
		.rd         (rd),
		.result     (result),
		.store_data (store_data),
		.dest_reg   (dest_reg),
		.reg_wen    (reg_wen),
		.mem_op     (mem_op),
		.halt       (halt)
	);

	// stall acts as the inverse enable of EX/MEM
	ex_mem_reg ex_mem_reg_inst (
		.CLK               (CLK),
		.nRST              (nRST),
		.stall             (stall),
		.flush             (flush),
		.result            (result),
		.store_data        (store_data),
		.dest_reg          (dest_reg),
		.reg_wen           (reg_wen),
		.mem_op            (mem_op),
		.halt              (halt),
		.result_ex_mem     (result_ex_mem),
		.store_data_ex_mem (store_data_ex_mem),
		.dest_reg_ex_mem   (dest_reg_ex_mem),
		.reg_wen_ex_mem    (reg_wen_ex_mem),
		.mem_op_ex_mem     (mem_op_ex_mem),
		.halt_ex_mem       (halt_ex_mem)
	);

	mem_stage #(
		.DMEM_CREDITS (DMEM_CREDITS)
	) mem_stage_inst (
		.CLK               (CLK),
		.nRST              (nRST),
		.mem_op_ex_mem     (mem_op_ex_mem),
		.result_ex_mem     (result_ex_mem),
		.store_data_ex_mem (store_data_ex_mem),
		.dmem_credit       (dmem_credit),
		.dmem_rvalid       (dmem_rvalid),
		.dmem_rdata        (dmem_rdata),
		.dmem_req          (dmem_req),
		.dmem_we           (dmem_we),
		.dmem_addr         (dmem_addr),
		.dmem_wdata        (dmem_wdata),
		.stall             (stall),
		.load_data         (load_data)
	);

	mem_wb_reg mem_wb_reg_inst (
		.CLK             (CLK),
		.nRST            (nRST),
		.stall           (stall),
		.result_ex_mem   (result_ex_mem),
		.load_data       (load_data),
		.dest_reg_ex_mem (dest_reg_ex_mem),
		.reg_wen_ex_mem  (reg_wen_ex_mem),
		.mem_op_ex_mem   (mem_op_ex_mem),
		.halt_ex_mem     (halt_ex_mem),
		.wb_wen          (wb_wen),
		.wb_addr         (wb_addr),
		.wb_data         (wb_data),
		.halt_out        (halt_out)
	);

endmodule

// File: ex_mem_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// assertions for the memory stage
// credit use, load stall, reset values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ex_mem_assert #(
	parameter int DMEM_CREDITS = 2,
	parameter int CNT_W = 2
) (
	input logic             CLK,
	input logic             nRST,
	input logic             dmem_req,
	input logic             dmem_we,
	input logic             dmem_credit,
	input logic             dmem_rvalid,
	input logic             stall,
	input logic             issued_reg,
	input logic [CNT_W-1:0] credits_reg
);

	int   fail_count = 0;
	// requests seen on the port and not yet given back
	int   outstanding;
	logic load_wait;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			outstanding <= 0;
			load_wait <= 1'b0;
		end else begin
			outstanding <= outstanding + int'(dmem_req) - int'(dmem_credit);
			if (dmem_req && !dmem_we)
				load_wait <= 1'b1;
			else if (dmem_rvalid)
				load_wait <= 1'b0;
		end
	end

	// request only with a credit in hand
	assert property (@(posedge CLK) disable iff (!nRST)
		dmem_req |-> outstanding < DMEM_CREDITS)
		else begin
			fail_count++;
			$error("data memory request with no credit left");
		end

	// credit count matches the requests still out
	assert property (@(posedge CLK) disable iff (!nRST)
		credits_reg == DMEM_CREDITS - outstanding)
		else begin
			fail_count++;
			$error("credit count %0d with %0d requests outstanding", credits_reg, outstanding);
		end

	// a load holds the pipeline from its request until its data
	assert property (@(posedge CLK) disable iff (!nRST)
		((dmem_req && !dmem_we) || (load_wait && !dmem_rvalid)) |-> stall)
		else begin
			fail_count++;
			$error("stall low while a load waits for data");
		end

	// state one edge into reset
	assert property (@(posedge CLK)
		!nRST |=> !stall && !dmem_req && !issued_reg && credits_reg == DMEM_CREDITS)
		else begin
			fail_count++;
			$error("memory stage not in its reset state");
		end

endmodule

// File: tb_wb_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback and halt checker
// in-order compare against expected queues
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_wb_checker import cpu_types_pkg::*; (
	input logic     CLK,
	input logic     nRST,
	input logic     wb_wen,
	input regbits_t wb_addr,
	input word_t    wb_data,
	input logic     halt_out,
	input int       cycle_count
);

	int       line_q[$];
	regbits_t addr_q[$];
	word_t    data_q[$];
	int       due_q[$];
	int       halt_line_q[$];
	int       halt_due_q[$];
	int       pass_count = 0;
	int       error_count = 0;

	// due of zero means any cycle
	task automatic expect_write(input int line, input regbits_t addr, input word_t data,
		input int due);
		line_q.push_back(line);
		addr_q.push_back(addr);
		data_q.push_back(data);
		due_q.push_back(due);
	endtask

	task automatic expect_halt(input int line, input int due);
		halt_line_q.push_back(line);
		halt_due_q.push_back(due);
	endtask

	function automatic int pending_count();
		return line_q.size() + halt_line_q.size();
	endfunction

	task automatic report_counts();
		$display("%0d checks passed, %0d errors", pass_count, error_count);
	endtask

	task automatic check_write();
		int       line;
		int       due;
		regbits_t exp_addr;
		word_t    exp_data;
		logic     ok;
		if (line_q.size() == 0) begin
			error_count++;
			$display("writeback to register %0d with nothing expected", wb_addr);
		end else begin
			line = line_q.pop_front();
			exp_addr = addr_q.pop_front();
			exp_data = data_q.pop_front();
			due = due_q.pop_front();
			ok = 1'b1;
			if (wb_addr !== exp_addr) begin
				$display("Fail line %0d: wb_addr %h, expected %h", line, wb_addr, exp_addr);
				ok = 1'b0;
			end
			if (wb_data !== exp_data) begin
				$display("Fail line %0d: wb_data %h, expected %h", line, wb_data, exp_data);
				ok = 1'b0;
			end
			if (due != 0 && cycle_count != due) begin
				$display("line %0d: writeback came in cycle %0d, not %0d", line, cycle_count, due);
				ok = 1'b0;
			end
			if (ok) begin
				pass_count++;
				$display("line %0d: r%0d = %h ok", line, wb_addr, wb_data);
			end else
				error_count++;
		end
	endtask

	task automatic check_halt();
		int line;
		int due;
		if (halt_line_q.size() == 0) begin
			error_count++;
			$display("halt raised with no halt instruction pending");
		end else begin
			line = halt_line_q.pop_front();
			due = halt_due_q.pop_front();
			if (cycle_count != due) begin
				error_count++;
				$display("line %0d: halt came in cycle %0d, not %0d", line, cycle_count, due);
			end else begin
				pass_count++;
				$display("line %0d: halt ok", line);
			end
		end
	endtask

	// outputs are settled mid cycle
	always @(negedge CLK) begin
		if (!nRST) begin
			if (wb_wen || halt_out) begin
				error_count++;
				$display("writeback or halt active during reset");
			end
		end else begin
			if (wb_wen)
				check_write();
			if (halt_out)
				check_halt();
		end
	end

endmodule

// File: tb_ex_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top for the EX/MEM/WB pipeline
// clock, reset, file stimulus, timeout and
// data memory model with random latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_ex_mem import cpu_types_pkg::*; ();

	localparam int DMEM_CREDITS = 2;
	localparam int MAX_LINES = 64;
	localparam int LINE_W = 176;

	logic     CLK, nRST, flush;
	opcode_t  opcode;
	aluop_t   alu_op;
	word_t    rdat1, rdat2, imm16_ext;
	regbits_t rt, rd;
	logic     dmem_credit, dmem_rvalid;
	word_t    dmem_rdata;
	logic     stall, wb_wen, halt_out, dmem_req, dmem_we;
	regbits_t wb_addr;
	word_t    wb_data, dmem_addr, dmem_wdata;

	logic [LINE_W-1:0] test_lines [MAX_LINES];
	int       num_lines;
	int       cycle_count = 0;
	int       cycle_limit = 0;
	int       seed;
	word_t    data_mem [16];
	// outstanding memory requests, oldest first
	word_t    req_addr_q[$];
	logic     req_we_q[$];
	int       req_due_q[$];
	logic     rdata_sent;

	ex_mem_top #(.DMEM_CREDITS(DMEM_CREDITS)) ex_mem_top_inst (.*);

	tb_wb_checker wb_checker_inst (.*);

	bind mem_stage ex_mem_assert #(.DMEM_CREDITS(DMEM_CREDITS), .CNT_W(CNT_W)) ex_mem_assert_inst (
		.CLK         (CLK),
		.nRST        (nRST),
		.dmem_req    (dmem_req),
		.dmem_we     (dmem_we),
		.dmem_credit (dmem_credit),
		.dmem_rvalid (dmem_rvalid),
		.stall       (stall),
		.issued_reg  (issued_reg),
		.credits_reg (credits_reg)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: no end of run after %0d cycles", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	// requests are accepted on the edge after this sample
	always @(negedge CLK) begin
		if (nRST && dmem_req) begin
			if (dmem_we)
				data_mem[dmem_addr[5:2]] = dmem_wdata;
			req_addr_q.push_back(dmem_addr);
			req_we_q.push_back(dmem_we);
			req_due_q.push_back(cycle_count + 1 + ({$random(seed)} % 4));
		end
	end

	initial begin : mem_response
		dmem_credit = 1'b0;
		dmem_rvalid = 1'b0;
		dmem_rdata = '0;
		rdata_sent = 1'b0;
		for (int i = 0; i < 16; i++)
			data_mem[i] = 32'hD0D0_0000 | (i << 2);
		forever begin
			@(posedge CLK);
			#2;
			dmem_credit = 1'b0;
			dmem_rvalid = 1'b0;
			if (req_due_q.size() != 0 && cycle_count >= req_due_q[0]) begin
				if (!req_we_q[0] && !rdata_sent) begin
					// load data first, its credit one cycle later
					dmem_rvalid = 1'b1;
					dmem_rdata = data_mem[req_addr_q[0][5:2]];
					rdata_sent = 1'b1;
				end else begin
					dmem_credit = 1'b1;
					rdata_sent = 1'b0;
					void'(req_addr_q.pop_front());
					void'(req_we_q.pop_front());
					void'(req_due_q.pop_front());
				end
			end
		end
	end

	task automatic issue_line(input logic [LINE_W-1:0] line, input int idx);
		logic taken;
		opcode = opcode_t'(line[169:164]);
		alu_op = aluop_t'(line[163:160]);
		rdat1 = line[159:128];
		rdat2 = line[127:96];
		imm16_ext = line[95:64];
		rt = line[60:56];
		rd = line[52:48];
		flush = (line[175:172] == 4'h2);
		taken = 1'b0;
		// hold the inputs until EX/MEM takes them
		while (!taken) begin
			@(negedge CLK);
			taken = !stall || flush;
			@(posedge CLK);
			#2;
		end
		// loads have open latency, everything else lands two edges on
		if (line[44])
			wb_checker_inst.expect_write(idx, line[40:36], line[35:4],
				(opcode == OP_LW) ? 0 : cycle_count + 1);
		if (line[0])
			wb_checker_inst.expect_halt(idx, cycle_count + 1);
		flush = 1'b0;
	endtask

	initial begin : stimulus
		int errors;
		seed = 5193;
		nRST = 1'b0;
		flush = 1'b0;
		opcode = OP_RTYPE;
		alu_op = ALU_ADD;
		rdat1 = '0;
		rdat2 = '0;
		imm16_ext = '0;
		rt = '0;
		rd = '0;
		$readmemh("ex_mem_tests.txt", test_lines);
		num_lines = 0;
		while (num_lines < MAX_LINES && !$isunknown(test_lines[num_lines]))
			num_lines++;
		errors = (num_lines == 0);
		if (num_lines == 0)
			$display("no test lines could be read from ex_mem_tests.txt");
		cycle_limit = 20 * num_lines + 50;
		repeat (3) @(posedge CLK);
		#2;
		nRST = 1'b1;
		for (int i = 0; i < num_lines; i++)
			issue_line(test_lines[i], i + 1);
		// idle on an r0 write
		opcode = OP_RTYPE;
		rd = REG_ZERO;
		while (wb_checker_inst.pending_count() != 0 || req_due_q.size() != 0)
			@(posedge CLK);
		repeat (2) @(posedge CLK);
		wb_checker_inst.report_counts();
		errors = errors + wb_checker_inst.error_count
			+ ex_mem_top_inst.mem_stage_inst.ex_mem_assert_inst.fail_count;
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: ex_mem_tests.txt
// kind_opcode_aluop_rdat1_rdat2_imm_rt_rd_wen_wbaddr_wbdata_halt
// kind 1 issues the instruction, kind 2 issues it with flush high
1_00_0_00000005_00000003_00000000_01_03_1_03_00000008_0
1_00_1_00000003_00000005_00000000_01_04_1_04_FFFFFFFE_0
1_00_2_F0F0F0F0_0FF00FF0_00000000_01_05_1_05_00F000F0_0
1_00_3_F0F0F0F0_0F0F0000_00000000_01_06_1_06_FFFFF0F0_0
1_00_4_AAAA5555_FFFF0000_00000000_01_07_1_07_55555555_0
1_00_5_0000FF00_00FF0000_00000000_01_08_1_08_FF0000FF_0
1_00_6_FFFFFFF0_00000002_00000000_01_09_1_09_00000001_0
1_00_7_00000001_00000024_00000000_01_0A_1_0A_00000010_0
1_00_8_80000000_0000001F_00000000_01_0B_1_0B_00000001_0
1_08_0_00000010_12345678_FFFFFFFF_0C_1F_1_0C_0000000F_0
1_0C_2_12345678_00000000_0000FFFF_0D_1F_1_0D_00005678_0
1_0D_3_12340000_00000000_00005678_0E_1F_1_0E_12345678_0
1_00_0_00000001_00000001_00000000_01_00_0_00_00000000_0
2_00_0_00000077_00000000_00000000_01_10_0_00_00000000_0
1_2B_1_00000000_CAFEF00D_00000010_11_00_0_00_00000000_0
1_08_0_00000001_00000000_00000001_12_00_1_12_00000002_0
2_2B_0_00000010_BADBAD00_00000000_13_00_0_00_00000000_0
1_23_4_00000008_00000000_00000008_13_00_1_13_CAFEF00D_0
1_2B_0_00000020_11112222_00000000_14_00_0_00_00000000_0
1_23_0_00000020_00000000_00000000_14_00_1_14_11112222_0
1_23_0_00000000_00000000_00000010_15_00_1_15_CAFEF00D_0
1_3F_0_00000000_00000000_00000000_00_00_0_00_00000000_1

// File: build.f
cpu_types_pkg.sv
ex_stage.sv
ex_mem_reg.sv
mem_stage.sv
mem_wb_reg.sv
ex_mem_top.sv
ex_mem_assert.sv
tb_wb_checker.sv
tb_ex_mem.sv

// File: Bender.yml
package:
  name: ex_mem_pipeline

sources:
  - files:
      - cpu_types_pkg.sv
      - ex_stage.sv
      - ex_mem_reg.sv
      - mem_stage.sv
      - mem_wb_reg.sv
      - ex_mem_top.sv
  - target: test
    files:
      - ex_mem_assert.sv
      - tb_wb_checker.sv
      - tb_ex_mem.sv
